// File: files.f
+incdir+logic
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_mul_unit.sv
logic/rv_lsu.sv
logic/rv_control.sv
logic/rv_core.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
  -f files.f -o rv_core_sim > build.log 2>&1 \
  && ./obj_dir/rv_core_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
grep -q "Simulation completed successfully" sim.log && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }

// File: sim/rv_core_tb.sv
module rv_core_tb;

  localparam int RUN_BUDGET = 6000;
  // four basic programs twice plus four trap programs
  localparam int NUM_RUNS = 12;
  localparam int WATCHDOG_TIME = RUN_BUDGET * NUM_RUNS * 2 * 4;
  localparam int DATA_IDX = 256;
  localparam int RES_IDX = 320;
  localparam rv_pkg::word_t MARKER_ADDR = 32'h0000_0FFC;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic mem_ready = 1'b0;
  rv_pkg::word_t mem_rdata = '0;
  logic mem_valid, mem_instr, trap;
  rv_pkg::word_t mem_addr, mem_wdata;
  rv_pkg::strb_t mem_wstrb;

  rv_pkg::word_t mem [1024];
  rv_pkg::word_t prog [$];
  rv_pkg::word_t exp_q [$];
  rv_pkg::strb_t strb_log [$];
  rv_pkg::word_t addr_log [$];
  rv_pkg::word_t mul_a [6];
  rv_pkg::word_t mul_b [6];
  int mismatches = 0;
  int failures = 0;
  int wait_cnt = 0;
  int cur_wait = 0;
  int write_count = 0;
  integer seed = 32'h4404;
  logic rand_waits = 1'b0;
  logic marker_hit = 1'b0;

  always #2 clk = ~clk;

  rv_core i_dut (
    .clk, .reset, .mem_valid, .mem_instr, .mem_ready, .mem_addr,
    .mem_wdata, .mem_wstrb, .mem_rdata, .trap
  );

  // memory model that answers on the falling edge
  always @(negedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      wait_cnt = 0;
      cur_wait = 0;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
    end else if (mem_valid) begin
      if (wait_cnt < cur_wait) begin
        wait_cnt++;
      end else begin
        // programs sit below the data area, so only they are fetched
        check_bit("mem_instr", mem_instr, mem_addr < rv_pkg::word_t'(DATA_IDX * 4));
        mem_rdata <= mem[mem_addr[11:2]];
        for (int i = 0; i < 4; i++) begin
          if (mem_wstrb[i]) mem[mem_addr[11:2]][8*i +: 8] = mem_wdata[8*i +: 8];
        end
        if (mem_wstrb != '0) begin
          write_count++;
          strb_log.push_back(mem_wstrb);
          addr_log.push_back(mem_addr);
        end
        mem_ready <= 1'b1;
        wait_cnt = 0;
        cur_wait = rand_waits ? int'($unsigned($random(seed)) % 4) : 0;
      end
    end
  end

  always @(posedge clk) begin
    if (reset) marker_hit <= 1'b0;
    else if (mem_valid && mem_ready && mem_wstrb != '0 && mem_addr == MARKER_ADDR)
      marker_hit <= 1'b1;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired after %0d time units", WATCHDOG_TIME);
    $display("Simulation failed");
    $finish;
  end

  function automatic rv_pkg::word_t fill_word(int i);
    return 32'h5A5A_0000 ^ (i * 32'h9E37_79B1);
  endfunction

  function automatic rv_pkg::word_t enc_r(int f7, int rs2, int rs1, int f3, int rd, int op);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic rv_pkg::word_t enc_i(int imm, int rs1, int f3, int rd, int op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic rv_pkg::word_t enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_pkg::word_t enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic rv_pkg::word_t enc_u(int imm20, int rd, int op);
    return {imm20[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic rv_pkg::word_t enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic rv_pkg::word_t addi(int rd, int rs1, int imm);
    return enc_i(imm, rs1, 0, rd, 7'b0010011);
  endfunction

  function automatic rv_pkg::word_t sx12(int imm);
    return {{20{imm[11]}}, imm[11:0]};
  endfunction

  // taken condition of each branch kind, by funct3
  function automatic logic branch_expect(int f3, rv_pkg::word_t a, rv_pkg::word_t b);
    case (f3)
      0: return a == b;
      1: return a != b;
      4: return $signed(a) < $signed(b);
      5: return $signed(a) >= $signed(b);
      6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic rv_pkg::word_t mul_expect(int f3, rv_pkg::word_t a, rv_pkg::word_t b);
    logic [63:0] ea, eb, p;
    ea = (f3 == 1 || f3 == 2) ? {{32{a[31]}}, a} : {32'b0, a};
    eb = (f3 == 1) ? {{32{b[31]}}, b} : {32'b0, b};
    p = ea * eb;
    return (f3 == 0) ? p[31:0] : p[63:32];
  endfunction

  task automatic check_word(input string name, input rv_pkg::word_t got, input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_strb(input string name, input rv_pkg::strb_t got, input rv_pkg::strb_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      mismatches++;
    end
  endtask

  task automatic emit(input rv_pkg::word_t w);
    prog.push_back(w);
  endtask

  task automatic store_reg(input int r, input rv_pkg::word_t e);
    emit(enc_s(exp_q.size() * 4, r, 10, 2));
    exp_q.push_back(e);
  endtask

  // the instruction writes x3, which is then stored to the next result slot
  task automatic op_and_store(input rv_pkg::word_t w, input rv_pkg::word_t e);
    emit(w);
    store_reg(3, e);
  endtask

  task automatic start_program();
    @(negedge clk);
    reset <= 1'b1;
    repeat (2) @(negedge clk);
    for (int i = 0; i < 1024; i++) mem[i] = fill_word(i);
    prog.delete();
    exp_q.delete();
    strb_log.delete();
    addr_log.delete();
    write_count = 0;
    // x9 data base, x10 result base, x11 marker page
    emit(addi(9, 0, 12'h400));
    emit(addi(10, 0, 12'h500));
    emit(enc_u(1, 11, 7'b0110111));
  endtask

  task automatic finish_program();
    emit(enc_s(-4, 0, 11, 2));
    emit(enc_j(0, 0));
    for (int i = 0; i < prog.size(); i++) mem[i] = prog[i];
  endtask

  task automatic run_program(input string name, input logic expect_trap);
    int cycles;
    cycles = 0;
    reset <= 1'b0;
    while (!marker_hit && !trap && cycles < RUN_BUDGET) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles >= RUN_BUDGET) begin
      $display("%s: program did not finish within %0d cycles", name, RUN_BUDGET);
      failures++;
    end
    check_bit({name, " trap"}, trap, expect_trap);
  endtask

  task automatic check_results(input string name);
    for (int k = 0; k < exp_q.size(); k++)
      check_word($sformatf("%s result %0d", name, k), mem[RES_IDX+k], exp_q[k]);
  endtask

  task automatic test_alu();
    rv_pkg::word_t a, b, p;
    a = 32'h9ABC_DEF1;
    b = 32'h1234_5677;
    start_program();
    mem[DATA_IDX] = a;
    mem[DATA_IDX+1] = b;
    emit(enc_i(0, 9, 2, 1, 7'b0000011));
    emit(enc_i(4, 9, 2, 2, 7'b0000011));
    op_and_store(enc_r(0, 2, 1, 0, 3, 7'b0110011), a + b);
    op_and_store(enc_r(7'h20, 2, 1, 0, 3, 7'b0110011), a - b);
    op_and_store(enc_r(0, 2, 1, 1, 3, 7'b0110011), a << b[4:0]);
    op_and_store(enc_r(0, 2, 1, 2, 3, 7'b0110011), {31'b0, $signed(a) < $signed(b)});
    op_and_store(enc_r(0, 2, 1, 3, 3, 7'b0110011), {31'b0, a < b});
    op_and_store(enc_r(0, 2, 1, 4, 3, 7'b0110011), a ^ b);
    op_and_store(enc_r(0, 2, 1, 5, 3, 7'b0110011), a >> b[4:0]);
    op_and_store(enc_r(7'h20, 2, 1, 5, 3, 7'b0110011), $signed(a) >>> b[4:0]);
    op_and_store(enc_r(0, 2, 1, 6, 3, 7'b0110011), a | b);
    op_and_store(enc_r(0, 2, 1, 7, 3, 7'b0110011), a & b);
    op_and_store(addi(3, 1, -5), a + sx12(-5));
    op_and_store(enc_i(12'h7FF, 1, 2, 3, 7'b0010011), {31'b0, $signed(a) < $signed(sx12(12'h7FF))});
    op_and_store(enc_i(-1, 1, 3, 3, 7'b0010011), {31'b0, a < sx12(-1)});
    op_and_store(enc_i(12'h5A5, 1, 4, 3, 7'b0010011), a ^ sx12(12'h5A5));
    op_and_store(enc_i(12'h0F0, 1, 6, 3, 7'b0010011), a | sx12(12'h0F0));
    op_and_store(enc_i(12'h8FF, 1, 7, 3, 7'b0010011), a & sx12(12'h8FF));
    op_and_store(enc_i(7, 1, 1, 3, 7'b0010011), a << 7);
    op_and_store(enc_i(9, 1, 5, 3, 7'b0010011), a >> 9);
    op_and_store(enc_i(12'h409, 1, 5, 3, 7'b0010011), $signed(a) >>> 9);
    op_and_store(enc_u(20'hABCDE, 3, 7'b0110111), 32'hABCD_E000);
    p = rv_pkg::word_t'(prog.size() * 4);
    op_and_store(enc_u(20'h12345, 3, 7'b0010111), p + 32'h1234_5000);
    finish_program();
    run_program("alu", 1'b0);
    check_results("alu");
  endtask

  task automatic test_branch();
    int f3s [6] = '{0, 1, 4, 5, 6, 7};
    int ra [3] = '{1, 2, 1};
    int rb [3] = '{2, 1, 1};
    rv_pkg::word_t q;
    start_program();
    emit(addi(1, 0, -3));
    emit(addi(2, 0, 5));
    for (int o = 0; o < 3; o++) begin
      for (int k = 0; k < 6; k++) begin
        emit(addi(3, 0, 1));
        emit(enc_b(8, rb[o], ra[o], f3s[k]));
        op_and_store(addi(3, 0, 2), branch_expect(f3s[k], (ra[o] == 1) ? -32'sd3 : 32'd5,
                                                  (rb[o] == 1) ? -32'sd3 : 32'd5) ? 1 : 2);
      end
    end
    emit(addi(5, 0, 1));
    q = rv_pkg::word_t'(prog.size() * 4);
    emit(enc_j(8, 4));
    emit(addi(5, 0, 2));
    store_reg(4, q + 4);
    store_reg(5, 1);
    q = rv_pkg::word_t'(prog.size() * 4);
    emit(addi(6, 0, q + 12));
    emit(enc_i(0, 6, 0, 7, 7'b1100111));
    emit(addi(5, 0, 3));
    store_reg(7, q + 8);
    store_reg(5, 1);
    finish_program();
    run_program("branch", 1'b0);
    check_results("branch");
  endtask

  task automatic test_load_store();
    rv_pkg::word_t x, y, d, e;
    rv_pkg::strb_t strbs [6] = '{4'b0001, 4'b1000, 4'b0010, 4'b0100, 4'b0011, 4'b1100};
    rv_pkg::word_t addrs [6] = '{32'h600, 32'h600, 32'h604, 32'h604, 32'h608, 32'h60C};
    x = 32'hA1B2_C3D4;
    y = 32'h1357_9BDF;
    d = 32'h85F7_7A96;
    start_program();
    mem[DATA_IDX+1] = x;
    mem[DATA_IDX+2] = d;
    mem[DATA_IDX+3] = y;
    emit(enc_i(4, 9, 2, 1, 7'b0000011));
    emit(enc_i(12, 9, 2, 2, 7'b0000011));
    emit(enc_s(12'h200, 1, 9, 0));
    emit(enc_s(12'h203, 1, 9, 0));
    emit(enc_s(12'h205, 2, 9, 0));
    emit(enc_s(12'h206, 2, 9, 0));
    emit(enc_s(12'h208, 1, 9, 1));
    emit(enc_s(12'h20E, 2, 9, 1));
    for (int l = 0; l < 4; l++) begin
      op_and_store(enc_i(8 + l, 9, 0, 3, 7'b0000011), {{24{d[8*l+7]}}, d[8*l +: 8]});
      op_and_store(enc_i(8 + l, 9, 4, 3, 7'b0000011), {24'b0, d[8*l +: 8]});
    end
    op_and_store(enc_i(8, 9, 1, 3, 7'b0000011), {{16{d[15]}}, d[15:0]});
    op_and_store(enc_i(10, 9, 1, 3, 7'b0000011), {{16{d[31]}}, d[31:16]});
    op_and_store(enc_i(8, 9, 5, 3, 7'b0000011), {16'b0, d[15:0]});
    op_and_store(enc_i(10, 9, 5, 3, 7'b0000011), {16'b0, d[31:16]});
    op_and_store(enc_i(8, 9, 2, 3, 7'b0000011), d);
    finish_program();
    run_program("load_store", 1'b0);
    check_results("load_store");
    if (strb_log.size() < 6) begin
      $display("load_store: only %0d stores seen", strb_log.size());
      failures++;
    end else begin
      for (int k = 0; k < 6; k++) begin
        check_strb($sformatf("store %0d mem_wstrb", k), strb_log[k], strbs[k]);
        check_word($sformatf("store %0d mem_addr", k), addr_log[k], addrs[k]);
      end
    end
    e = fill_word(384);
    e[7:0] = x[7:0];
    e[31:24] = x[7:0];
    check_word("byte lanes 0 and 3", mem[384], e);
    e = fill_word(385);
    e[23:8] = {y[7:0], y[7:0]};
    check_word("byte lanes 1 and 2", mem[385], e);
    e = fill_word(386);
    e[15:0] = x[15:0];
    check_word("low half", mem[386], e);
    e = fill_word(387);
    e[31:16] = y[15:0];
    check_word("high half", mem[387], e);
  endtask

  task automatic test_mul();
    int f3s [4] = '{0, 1, 2, 3};
    start_program();
    for (int k = 0; k < 6; k++) begin
      mem[DATA_IDX+2*k] = mul_a[k];
      mem[DATA_IDX+2*k+1] = mul_b[k];
      emit(enc_i(8 * k, 9, 2, 1, 7'b0000011));
      emit(enc_i(8 * k + 4, 9, 2, 2, 7'b0000011));
      for (int m = 0; m < 4; m++)
        op_and_store(enc_r(1, 2, 1, f3s[m], 3, 7'b0110011), mul_expect(f3s[m], mul_a[k], mul_b[k]));
    end
    finish_program();
    run_program("mul", 1'b0);
    check_results("mul");
  endtask

  task automatic after_trap(input string name);
    repeat (20) @(negedge clk);
    if (write_count != 0) begin
      $display("%s: memory was written by a program that should have trapped", name);
      failures++;
    end
  endtask

  task automatic test_traps();
    start_program();
    emit(32'h0000_0073);
    emit(enc_s(12'h300, 0, 9, 2));
    finish_program();
    run_program("undecoded", 1'b1);
    after_trap("undecoded");
    start_program();
    emit(addi(1, 0, 12'h402));
    emit(enc_i(0, 1, 2, 3, 7'b0000011));
    emit(enc_s(12'h300, 0, 9, 2));
    finish_program();
    run_program("misaligned lw", 1'b1);
    after_trap("misaligned lw");
    start_program();
    emit(enc_s(1, 0, 9, 1));
    emit(enc_s(12'h300, 0, 9, 2));
    finish_program();
    run_program("misaligned sh", 1'b1);
    after_trap("misaligned sh");
    start_program();
    emit(addi(6, 0, 12'h101));
    emit(enc_i(0, 6, 0, 7, 7'b1100111));
    emit(enc_s(12'h300, 0, 9, 2));
    finish_program();
    run_program("odd jalr", 1'b1);
    after_trap("odd jalr");
  endtask

  task automatic run_basic();
    test_alu();
    test_branch();
    test_load_store();
    test_mul();
  endtask

  initial begin
    mul_a[0] = $random(seed);
    mul_b[0] = $random(seed);
    mul_a[1] = $random(seed);
    mul_b[1] = $random(seed);
    mul_a[2] = 32'h8000_0000;
    mul_b[2] = 32'hFFFF_FFFF;
    mul_a[3] = 32'h8000_0000;
    mul_b[3] = 32'h8000_0000;
    mul_a[4] = 32'hFFFF_FFFF;
    mul_b[4] = 32'hFFFF_FFFF;
    mul_a[5] = 32'd7;
    mul_b[5] = 32'hFFFF_FFFD;
    run_basic();
    test_traps();
    // same programs again with memory wait states
    rand_waits = 1'b1;
    run_basic();
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim/rv_core_checker.sv
module rv_core_checker (
  input logic          clk,
  input logic          reset,
  input logic          mem_valid,
  input logic          mem_instr,
  input logic          mem_ready,
  input rv_pkg::word_t mem_addr,
  input rv_pkg::strb_t mem_wstrb,
  input logic          trap
);

  // request held with a fixed address until the memory accepts it
  hold_request: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
    else $error("memory request dropped or changed before mem_ready");

  fetch_no_strobe: assert property (@(posedge clk) disable iff (reset)
    mem_instr |-> mem_wstrb == '0)
    else $error("instruction fetch carries a write strobe");

  trap_sticky: assert property (@(posedge clk) disable iff (reset)
    trap |=> trap)
    else $error("trap fell without reset");

  trap_quiet: assert property (@(posedge clk) disable iff (reset)
    trap |-> !mem_valid)
    else $error("memory request issued after trap");

  reset_state: assert property (@(posedge clk) reset |=> !mem_valid && !trap)
    else $error("mem_valid or trap high right after reset");

endmodule

bind rv_core rv_core_checker i_checker (.*);

// File: logic/rv_core.sv
module rv_core (
  input  logic          clk,
  input  logic          reset,
  output logic          mem_valid,
  output logic          mem_instr,
  input  logic          mem_ready,
  output rv_pkg::word_t mem_addr,
  output rv_pkg::word_t mem_wdata,
  output rv_pkg::strb_t mem_wstrb,
  input  rv_pkg::word_t mem_rdata,
  output logic          trap
);

  rv_pkg::word_t instr, imm, rs1_data, rs2_data, rf_wdata, alu_result, mul_result;
  rv_pkg::word_t lsu_addr, lsu_wdata, load_value;
  rv_pkg::strb_t lsu_wstrb;
  rv_pkg::reg_idx_t rs1, rs2, rd;
  rv_pkg::op_class_e op_class;
  rv_pkg::alu_op_e alu_op;
  rv_pkg::branch_op_e branch_op;
  rv_pkg::mem_size_e mem_size;
  rv_pkg::mul_op_e mul_op;
  logic load_unsigned, rf_we, branch_taken, use_imm, mul_start, mul_done, misaligned;

  // second alu operand comes from the immediate for op-imm
  assign use_imm = (op_class == rv_pkg::cls_alu_imm);

  rv_control i_control (
    .clk, .reset, .mem_ready, .mem_rdata, .op_class, .imm, .rs1_data,
    .alu_result, .branch_taken, .mul_done, .mul_result,
    .lsu_addr, .lsu_wdata, .lsu_wstrb, .load_value, .misaligned,
    .mem_valid, .mem_instr, .mem_addr, .mem_wdata, .mem_wstrb,
    .instr, .rf_we, .rf_wdata, .mul_start, .trap
  );

  rv_decoder i_decoder (
    .instr, .op_class, .alu_op, .branch_op, .mem_size, .load_unsigned,
    .mul_op, .rs1, .rs2, .rd, .imm
  );

  rv_regfile i_regfile (
    .clk, .rs1, .rs2, .rd, .wdata(rf_wdata), .we(rf_we), .rs1_data, .rs2_data
  );

  rv_alu i_alu (
    .a(rs1_data), .b(rs2_data), .imm, .use_imm, .alu_op, .branch_op,
    .result(alu_result), .branch_taken
  );

  rv_mul_unit i_mul (
    .clk, .reset, .start(mul_start), .mul_op, .a(rs1_data), .b(rs2_data),
    .done(mul_done), .result(mul_result)
  );

  rv_lsu i_lsu (
    .base(rs1_data), .offset(imm), .store_data(rs2_data), .mem_size, .load_unsigned,
    .rdata(mem_rdata), .addr(lsu_addr), .wdata(lsu_wdata), .wstrb(lsu_wstrb),
    .load_value, .misaligned
  );

endmodule

// File: logic/rv_control.sv
`include "rv_cfg.svh"

module rv_control (
  input  logic              clk,
  input  logic              reset,
  input  logic              mem_ready,
  input  rv_pkg::word_t     mem_rdata,
  input  rv_pkg::op_class_e op_class,
  input  rv_pkg::word_t     imm,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     alu_result,
  input  logic              branch_taken,
  input  logic              mul_done,
  input  rv_pkg::word_t     mul_result,
  input  rv_pkg::word_t     lsu_addr,
  input  rv_pkg::word_t     lsu_wdata,
  input  rv_pkg::strb_t     lsu_wstrb,
  input  rv_pkg::word_t     load_value,
  input  logic              misaligned,
  output logic              mem_valid,
  output logic              mem_instr,
  output rv_pkg::word_t     mem_addr,
  output rv_pkg::word_t     mem_wdata,
  output rv_pkg::strb_t     mem_wstrb,
  output rv_pkg::word_t     instr,
  output logic              rf_we,
  output rv_pkg::word_t     rf_wdata,
  output logic              mul_start,
  output logic              trap
);

  rv_pkg::cpu_state_e state;
  rv_pkg::word_t pc, next_pc, target, wb_data, pc_plus4;

  assign pc_plus4 = pc + 4;
  assign rf_we = (state == rv_pkg::st_write_back);
  assign rf_wdata = wb_data;
  assign mul_start = (state == rv_pkg::st_execute) && (op_class == rv_pkg::cls_multiply);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_pkg::st_fetch;
      next_pc <= `RV_RESET_PC;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
      trap <= 1'b0;
    end else begin
      case (state)
        rv_pkg::st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= '0;
          mem_addr <= next_pc;
          state <= rv_pkg::st_wait_instr;
        end
        rv_pkg::st_wait_instr: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            mem_instr <= 1'b0;
            pc <= mem_addr;
            instr <= mem_rdata;
            state <= rv_pkg::st_execute;
          end
        end
        rv_pkg::st_execute: begin
          next_pc <= pc_plus4;
          case (op_class)
            rv_pkg::cls_lui, rv_pkg::cls_auipc, rv_pkg::cls_alu_reg, rv_pkg::cls_alu_imm: begin
              if (op_class == rv_pkg::cls_lui) wb_data <= imm;
              else if (op_class == rv_pkg::cls_auipc) wb_data <= pc + imm;
              else wb_data <= alu_result;
              state <= rv_pkg::st_write_back;
            end
            // jalr keeps bit 0 so an odd target traps in check_pc
            rv_pkg::cls_jal, rv_pkg::cls_jalr, rv_pkg::cls_branch: begin
              if (op_class == rv_pkg::cls_jalr) target <= rs1_data + imm;
              else if (op_class == rv_pkg::cls_branch && !branch_taken) target <= pc_plus4;
              else target <= pc + imm;
              wb_data <= pc_plus4;
              state <= rv_pkg::st_check_pc;
            end
            rv_pkg::cls_load, rv_pkg::cls_store: begin
              if (misaligned) begin
                state <= rv_pkg::st_trapped;
              end else begin
                mem_valid <= 1'b1;
                mem_instr <= 1'b0;
                mem_addr <= lsu_addr;
                mem_wdata <= lsu_wdata;
                if (op_class == rv_pkg::cls_store) begin
                  mem_wstrb <= lsu_wstrb;
                  state <= rv_pkg::st_store_wait;
                end else begin
                  mem_wstrb <= '0;
                  state <= rv_pkg::st_load_wait;
                end
              end
            end
            rv_pkg::cls_multiply: state <= rv_pkg::st_mul_wait;
            default: state <= rv_pkg::st_trapped;
          endcase
        end
        rv_pkg::st_mul_wait: begin
          if (mul_done) begin
            wb_data <= mul_result;
            state <= rv_pkg::st_write_back;
          end
        end
        rv_pkg::st_load_wait: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            wb_data <= load_value;
            state <= rv_pkg::st_write_back;
          end
        end
        rv_pkg::st_store_wait: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            mem_wstrb <= '0;
            state <= rv_pkg::st_fetch;
          end
        end
        rv_pkg::st_check_pc: begin
          if (target[1:0] != 2'b00) begin
            state <= rv_pkg::st_trapped;
          end else begin
            next_pc <= target;
            // only jumps write a link value
            state <= (op_class == rv_pkg::cls_branch) ? rv_pkg::st_fetch : rv_pkg::st_write_back;
          end
        end
        rv_pkg::st_write_back: state <= rv_pkg::st_fetch;
        default: trap <= 1'b1;
      endcase
    end
  end

endmodule

// File: logic/rv_lsu.sv
module rv_lsu (
  input  rv_pkg::word_t     base,
  input  rv_pkg::word_t     offset,
  input  rv_pkg::word_t     store_data,
  input  rv_pkg::mem_size_e mem_size,
  input  logic              load_unsigned,
  input  rv_pkg::word_t     rdata,
  output rv_pkg::word_t     addr,
  output rv_pkg::word_t     wdata,
  output rv_pkg::strb_t     wstrb,
  output rv_pkg::word_t     load_value,
  output logic              misaligned
);

  rv_pkg::word_t ea;
  rv_pkg::word_t shifted;
  logic [1:0] lane;

  assign ea = base + offset;
  assign lane = ea[1:0];
  assign addr = ea & ~rv_pkg::word_t'(3);
  // move the addressed byte or half down to bit 0
  assign shifted = rdata >> {lane, 3'b000};

  always_comb begin
    case (mem_size)
      rv_pkg::size_byte: begin
        wdata = {4{store_data[7:0]}};
        wstrb = 4'b0001 << lane;
        load_value = load_unsigned ? {24'b0, shifted[7:0]} :
                                     {{24{shifted[7]}}, shifted[7:0]};
        misaligned = 1'b0;
      end
      rv_pkg::size_half: begin
        wdata = {2{store_data[15:0]}};
        wstrb = lane[1] ? 4'b1100 : 4'b0011;
        load_value = load_unsigned ? {16'b0, shifted[15:0]} :
                                     {{16{shifted[15]}}, shifted[15:0]};
        misaligned = lane[0];
      end
      default: begin
        wdata = store_data;
        wstrb = 4'b1111;
        load_value = rdata;
        misaligned = |lane;
      end
    endcase
  end

endmodule

// File: logic/rv_mul_unit.sv
`include "rv_cfg.svh"

module rv_mul_unit (
  input  logic            clk,
  input  logic            reset,
  input  logic            start,
  input  rv_pkg::mul_op_e mul_op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  output logic            done,
  output rv_pkg::word_t   result
);

  localparam int W = `RV_XLEN;
  localparam int CW = $clog2(`RV_MUL_HI_STEPS + 1);

  logic [2*W-1:0] x, y, acc;
  logic [CW-1:0] count;
  logic busy, hi_sel, a_signed, b_signed;

  always_comb begin
    case (mul_op)
      rv_pkg::mul_mulh:   {a_signed, b_signed} = 2'b11;
      rv_pkg::mul_mulhsu: {a_signed, b_signed} = 2'b10;
      default:            {a_signed, b_signed} = 2'b00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      x <= {{W{a_signed & a[W-1]}}, a};
      y <= {{W{b_signed & b[W-1]}}, b};
      acc <= '0;
      hi_sel <= (mul_op != rv_pkg::mul_mul);
      // low half only needs one pass over the low multiplier bits
      count <= (mul_op == rv_pkg::mul_mul) ? CW'(`RV_MUL_LO_STEPS) : CW'(`RV_MUL_HI_STEPS);
    end else if (busy && count != '0) begin
      if (y[0]) begin
        acc <= acc + x;
      end
      x <= x << 1;
      y <= y >> 1;
      count <= count - 1'b1;
    end
  end

  assign done = busy && (count == '0);
  assign result = hi_sel ? acc[2*W-1:W] : acc[W-1:0];

endmodule

// File: logic/rv_alu.sv
module rv_alu (
  input  rv_pkg::word_t      a,
  input  rv_pkg::word_t      b,
  input  rv_pkg::word_t      imm,
  input  logic               use_imm,
  input  rv_pkg::alu_op_e    alu_op,
  input  rv_pkg::branch_op_e branch_op,
  output rv_pkg::word_t      result,
  output logic               branch_taken
);

  rv_pkg::word_t operand;
  logic [4:0] shamt;

  assign operand = use_imm ? imm : b;
  // shamt sits in imm[4:0] for the immediate shifts
  assign shamt = use_imm ? imm[4:0] : b[4:0];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  result = a + operand;
      rv_pkg::alu_sub:  result = a - operand;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = rv_pkg::word_t'($signed(a) < $signed(operand));
      rv_pkg::alu_sltu: result = rv_pkg::word_t'(a < operand);
      rv_pkg::alu_xor:  result = a ^ operand;
      rv_pkg::alu_srl:  result = a >> shamt;
      rv_pkg::alu_sra:  result = $signed(a) >>> shamt;
      rv_pkg::alu_or:   result = a | operand;
      default:          result = a & operand;
    endcase
  end

  // branches always compare the two registers
  always_comb begin
    case (branch_op)
      rv_pkg::br_beq:  branch_taken = (a == b);
      rv_pkg::br_bne:  branch_taken = (a != b);
      rv_pkg::br_blt:  branch_taken = ($signed(a) < $signed(b));
      rv_pkg::br_bge:  branch_taken = ($signed(a) >= $signed(b));
      rv_pkg::br_bltu: branch_taken = (a < b);
      default:         branch_taken = (a >= b);
    endcase
  end

endmodule

// File: logic/rv_regfile.sv
`include "rv_cfg.svh"

module rv_regfile (
  input  logic             clk,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    wdata,
  input  logic             we,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 is hardwired
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: logic/rv_decoder.sv
module rv_decoder (
  input  rv_pkg::word_t      instr,
  output rv_pkg::op_class_e  op_class,
  output rv_pkg::alu_op_e    alu_op,
  output rv_pkg::branch_op_e branch_op,
  output rv_pkg::mem_size_e  mem_size,
  output logic               load_unsigned,
  output rv_pkg::mul_op_e    mul_op,
  output rv_pkg::reg_idx_t   rs1,
  output rv_pkg::reg_idx_t   rs2,
  output rv_pkg::reg_idx_t   rd,
  output rv_pkg::word_t      imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    op_class = rv_pkg::cls_illegal;
    case (opcode)
      7'b0110111: op_class = rv_pkg::cls_lui;
      7'b0010111: op_class = rv_pkg::cls_auipc;
      7'b1101111: op_class = rv_pkg::cls_jal;
      7'b1100111: if (funct3 == 3'b000) op_class = rv_pkg::cls_jalr;
      7'b1100011: if (funct3[2:1] != 2'b01) op_class = rv_pkg::cls_branch;
      // lb lh lw lbu lhu
      7'b0000011: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) op_class = rv_pkg::cls_load;
      7'b0100011: if (!funct3[2] && funct3 != 3'b011) op_class = rv_pkg::cls_store;
      7'b0010011: begin
        if (funct3 == 3'b001) begin
          if (funct7 == 7'b0000000) op_class = rv_pkg::cls_alu_imm;
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'b0000000 || funct7 == 7'b0100000) op_class = rv_pkg::cls_alu_imm;
        end else begin
          op_class = rv_pkg::cls_alu_imm;
        end
      end
      7'b0110011: begin
        if (funct7 == 7'b0000000) op_class = rv_pkg::cls_alu_reg;
        else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))
          op_class = rv_pkg::cls_alu_reg;
        // only the multiply half of the M extension
        else if (funct7 == 7'b0000001 && !funct3[2]) op_class = rv_pkg::cls_multiply;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000: alu_op = (opcode[5] && funct7[5]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001: alu_op = rv_pkg::alu_sll;
      3'b010: alu_op = rv_pkg::alu_slt;
      3'b011: alu_op = rv_pkg::alu_sltu;
      3'b100: alu_op = rv_pkg::alu_xor;
      3'b101: alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110: alu_op = rv_pkg::alu_or;
      default: alu_op = rv_pkg::alu_and;
    endcase

    case (funct3)
      3'b000: branch_op = rv_pkg::br_beq;
      3'b001: branch_op = rv_pkg::br_bne;
      3'b100: branch_op = rv_pkg::br_blt;
      3'b101: branch_op = rv_pkg::br_bge;
      3'b110: branch_op = rv_pkg::br_bltu;
      default: branch_op = rv_pkg::br_bgeu;
    endcase

    case (funct3[1:0])
      2'b00: mem_size = rv_pkg::size_byte;
      2'b01: mem_size = rv_pkg::size_half;
      default: mem_size = rv_pkg::size_word;
    endcase

    case (funct3[1:0])
      2'b00: mul_op = rv_pkg::mul_mul;
      2'b01: mul_op = rv_pkg::mul_mulh;
      2'b10: mul_op = rv_pkg::mul_mulhsu;
      default: mul_op = rv_pkg::mul_mulhu;
    endcase

    case (op_class)
      rv_pkg::cls_lui, rv_pkg::cls_auipc: imm = imm_u;
      rv_pkg::cls_jal: imm = imm_j;
      rv_pkg::cls_branch: imm = imm_b;
      rv_pkg::cls_store: imm = imm_s;
      default: imm = imm_i;
    endcase
  end

  assign load_unsigned = funct3[2];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  // branches and stores have no destination
  assign rd = (op_class == rv_pkg::cls_branch || op_class == rv_pkg::cls_store) ?
              5'd0 : instr[11:7];

endmodule

// File: logic/rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [3:0] strb_t;

  typedef enum logic [3:0] {
    st_fetch, st_wait_instr, st_execute, st_mul_wait, st_load_wait,
    st_store_wait, st_check_pc, st_write_back, st_trapped
  } cpu_state_e;

  typedef enum logic [3:0] {
    cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load,
    cls_store, cls_alu_reg, cls_alu_imm, cls_multiply, cls_illegal
  } op_class_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_e;

  typedef enum logic [2:0] {
    br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } branch_op_e;

  // the unsigned load flag travels next to this
  typedef enum logic [1:0] {
    size_byte, size_half, size_word
  } mem_size_e;

  typedef enum logic [1:0] {
    mul_mul, mul_mulh, mul_mulhu, mul_mulhsu
  } mul_op_e;

endpackage

// File: logic/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 32
`define RV_NREGS 32
// address of the first instruction fetch
`define RV_RESET_PC 32'h0000_0000

// shift-add iterations for the low and the high product
`define RV_MUL_LO_STEPS 32
`define RV_MUL_HI_STEPS 64

`endif
